/* design/zxdma_pkg.sv */
package zxdma_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  typedef logic [15:0] addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] count_t;

  // Off, burst, timed, timed with restart
  typedef logic [1:0] dma_mode_t;
  // Bit 1 source is I/O, bit 0 destination is I/O
  typedef logic [1:0] dma_dir_t;

  //////////////////////////////////////////////////
  // Register indices and mode codes
  //////////////////////////////////////////////////

  localparam byte_t reg_ctrl = 8'hA0;
  localparam byte_t reg_src  = 8'hA1;
  localparam byte_t reg_dst  = 8'hA2;
  localparam byte_t reg_div  = 8'hA3;
  localparam byte_t reg_len  = 8'hA4;
  localparam byte_t reg_stat = 8'hA5;

  localparam dma_mode_t mode_off     = 2'd0;
  localparam dma_mode_t mode_burst   = 2'd1;
  localparam dma_mode_t mode_timed   = 2'd2;
  localparam dma_mode_t mode_restart = 2'd3;

  typedef enum logic [2:0] {
    idle,
    burst_check,
    timed_wait,
    timed_grant,
    xfer_rd,
    xfer_cap,
    xfer_wr,
    xfer_end
  } seq_state_t;

  typedef struct packed {
    dma_mode_t mode;
    dma_dir_t  dir;
    addr_t     src;
    addr_t     dst;
    count_t    divisor;
    count_t    length;
  } dma_cfg_t;

  typedef struct packed {
    addr_t a;
    byte_t dout;
    logic  mreq_n;
    logic  iorq_n;
    logic  rd_n;
    logic  wr_n;
  } dma_bus_t;

endpackage

/* design/dma_regs.sv */
module dma_regs import zxdma_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  byte_t    reg_addr,
  input  logic     reg_rd,
  input  logic     reg_wr,
  input  byte_t    din,
  input  logic     block_done,
  output dma_cfg_t cfg,
  output byte_t    dout,
  output logic     oe_n
);

  logic  wr_q;
  logic  wide_wr;
  logic  pend;
  byte_t pend_byte;
  byte_t pend_addr;
  logic  done_flag;
  logic  stat_rd;
  logic  stat_rd_q;

  assign wide_wr = reg_wr && (reg_addr inside {reg_src, reg_dst, reg_div, reg_len});
  assign stat_rd = reg_rd && (reg_addr == reg_stat);

  // Byte held until the CPU write strobe drops
  always_ff @(posedge clk) begin
    if (wide_wr) begin
      pend_byte <= din;
      pend_addr <= reg_addr;
    end
  end

  //////////////////////////////////////////////////
  // Register bank
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cfg       <= '0;
      wr_q      <= 1'b0;
      pend      <= 1'b0;
      done_flag <= 1'b0;
      stat_rd_q <= 1'b0;
    end else begin
      wr_q      <= reg_wr;
      stat_rd_q <= stat_rd;

      // CPU write takes priority over self-clearing
      if (reg_wr && !wr_q && reg_addr == reg_ctrl) begin
        cfg.dir  <= din[3:2];
        cfg.mode <= din[1:0];
      end else if (block_done && cfg.mode != mode_restart) begin
        cfg.mode <= mode_off;
      end

      // New byte enters at the top, old high byte moves down
      if (wide_wr) begin
        pend <= 1'b1;
      end else if (pend && !reg_wr) begin
        pend <= 1'b0;
        case (pend_addr)
          reg_src: cfg.src     <= {pend_byte, cfg.src[15:8]};
          reg_dst: cfg.dst     <= {pend_byte, cfg.dst[15:8]};
          reg_div: cfg.divisor <= {pend_byte, cfg.divisor[15:8]};
          reg_len: cfg.length  <= {pend_byte, cfg.length[15:8]};
          default: ;
        endcase
      end

      // Sticky until the status read has finished
      if (block_done) begin
        done_flag <= 1'b1;
      end else if (stat_rd_q && !stat_rd) begin
        done_flag <= 1'b0;
      end
    end
  end

  // Readback
  always_comb begin
    oe_n = 1'b1;
    dout = 8'hFF;
    if (reg_rd && reg_addr == reg_ctrl) begin
      oe_n = 1'b0;
      dout = {4'b0000, cfg.dir, cfg.mode};
    end else if (stat_rd) begin
      oe_n = 1'b0;
      dout = {done_flag, 5'b00000, cfg.mode};
    end
  end

endmodule

/* design/dma_pace_timer.sv */
module dma_pace_timer import zxdma_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  count_t divisor,
  input  logic   pace_restart,
  output logic   pace_tick
);

  count_t cnt;

  // Period is divisor+1 clocks
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (pace_restart || cnt == '0) begin
      cnt <= divisor;
    end else begin
      cnt <= cnt - 16'd1;
    end
  end

  assign pace_tick = (cnt == '0);

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // A reload with a nonzero divisor always leaves one idle cycle
  tick_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    (pace_tick && divisor != '0) |=> !pace_tick
  );

endmodule

/* design/dma_addr_gen.sv */
module dma_addr_gen import zxdma_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  dma_cfg_t cfg,
  input  logic     addr_load,
  input  logic     addr_step,
  output addr_t    src_ptr,
  output addr_t    dst_ptr,
  output logic     count_zero
);

  count_t remaining;

  //////////////////////////////////////////////////
  // Pointers
  //////////////////////////////////////////////////

  // I/O side stays on its port, memory side walks up
  always_ff @(posedge clk) begin
    if (addr_load) begin
      src_ptr <= cfg.src;
      dst_ptr <= cfg.dst;
    end else if (addr_step) begin
      if (!cfg.dir[1]) begin
        src_ptr <= src_ptr + 16'd1;
      end
      if (!cfg.dir[0]) begin
        dst_ptr <= dst_ptr + 16'd1;
      end
    end
  end

  // Bytes left in the block
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      remaining <= '0;
    end else if (addr_load) begin
      remaining <= cfg.length;
    end else if (addr_step) begin
      remaining <= remaining - 16'd1;
    end
  end

  assign count_zero = (remaining == '0);

  // Sequencer must not start a byte past the end of the block
  no_step_at_zero: assert property (
    @(posedge clk) disable iff (!rst_n) addr_step |-> !count_zero
  );

endmodule

/* design/dma_seq_fsm.sv */
module dma_seq_fsm import zxdma_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  dma_cfg_t cfg,
  input  logic     pace_tick,
  input  addr_t    src_ptr,
  input  addr_t    dst_ptr,
  input  logic     count_zero,
  input  logic     busak_n,
  input  byte_t    dma_din,
  output logic     busrq_n,
  output dma_bus_t bus,
  output logic     pace_restart,
  output logic     addr_load,
  output logic     addr_step,
  output logic     block_done
);

  seq_state_t state;
  seq_state_t state_next;
  logic       timed_mode;
  addr_t      addr_q;
  byte_t      data_q;
  logic       mreq_n_q;
  logic       iorq_n_q;
  logic       rd_n_q;
  logic       wr_n_q;

  assign timed_mode = (cfg.mode == mode_timed) || (cfg.mode == mode_restart);
  assign addr_step  = (state == xfer_end);

  //////////////////////////////////////////////////
  // Next state and control pulses
  //////////////////////////////////////////////////

  always_comb begin
    state_next   = state;
    addr_load    = 1'b0;
    pace_restart = 1'b0;
    block_done   = 1'b0;
    case (state)
      idle: begin
        if (cfg.mode == mode_burst) begin
          addr_load  = 1'b1;
          state_next = burst_check;
        end else if (timed_mode) begin
          addr_load    = 1'b1;
          pace_restart = 1'b1;
          state_next   = timed_wait;
        end
      end
      burst_check: begin
        if (cfg.mode != mode_burst) begin
          state_next = idle;
        end else if (count_zero) begin
          block_done = 1'b1;
          state_next = idle;
        end else if (!busak_n) begin
          state_next = xfer_rd;
        end
      end
      timed_wait: begin
        if (!timed_mode) begin
          state_next = idle;
        end else if (count_zero) begin
          block_done = 1'b1;
          if (cfg.mode == mode_restart) begin
            // Reload and run the block again
            addr_load    = 1'b1;
            pace_restart = 1'b1;
          end else begin
            state_next = idle;
          end
        end else if (pace_tick) begin
          state_next = timed_grant;
        end
      end
      timed_grant: begin
        if (!timed_mode) begin
          state_next = idle;
        end else if (!busak_n) begin
          state_next = xfer_rd;
        end
      end
      xfer_rd:  state_next = xfer_cap;
      xfer_cap: state_next = xfer_wr;
      xfer_wr:  state_next = xfer_end;
      xfer_end: state_next = (cfg.mode == mode_burst) ? burst_check : timed_wait;
      default:  state_next = idle;
    endcase
  end

  // Strobes are registered from the next state, so each is low for its whole phase
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= idle;
      busrq_n  <= 1'b1;
      mreq_n_q <= 1'b1;
      iorq_n_q <= 1'b1;
      rd_n_q   <= 1'b1;
      wr_n_q   <= 1'b1;
    end else begin
      state    <= state_next;
      busrq_n  <= (state_next == idle) || (state_next == timed_wait);
      rd_n_q   <= (state_next != xfer_rd);
      wr_n_q   <= (state_next != xfer_wr);
      mreq_n_q <= !((state_next == xfer_rd && !cfg.dir[1]) ||
                    (state_next == xfer_wr && !cfg.dir[0]));
      iorq_n_q <= !((state_next == xfer_rd && cfg.dir[1]) ||
                    (state_next == xfer_wr && cfg.dir[0]));
    end
  end

  // Address mux and data latch
  always_ff @(posedge clk) begin
    if (state_next == xfer_rd) begin
      addr_q <= src_ptr;
    end else if (state_next == xfer_wr) begin
      addr_q <= dst_ptr;
    end
    if (state == xfer_rd) begin
      data_q <= dma_din;
    end
  end

  assign bus.a      = addr_q;
  assign bus.dout   = data_q;
  assign bus.mreq_n = mreq_n_q;
  assign bus.iorq_n = iorq_n_q;
  assign bus.rd_n   = rd_n_q;
  assign bus.wr_n   = wr_n_q;

  //////////////////////////////////////////////////
  // Bus safety
  //////////////////////////////////////////////////

  rd_wr_excl: assert property (
    @(posedge clk) disable iff (!rst_n) !(!rd_n_q && !wr_n_q)
  );

  mreq_iorq_excl: assert property (
    @(posedge clk) disable iff (!rst_n) !(!mreq_n_q && !iorq_n_q)
  );

  // Bus must stay granted through every strobe
  strobe_granted: assert property (
    @(posedge clk) disable iff (!rst_n)
    (!mreq_n_q || !iorq_n_q || !rd_n_q || !wr_n_q) |-> !busak_n
  );

endmodule

/* design/zxdma_top.sv */
module zxdma_top import zxdma_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  byte_t    reg_addr,
  input  logic     reg_rd,
  input  logic     reg_wr,
  input  byte_t    din,
  output byte_t    dout,
  output logic     oe_n,
  output logic     busrq_n,
  input  logic     busak_n,
  input  byte_t    dma_din,
  output dma_bus_t bus
);

  dma_cfg_t cfg;
  logic     block_done;
  logic     pace_restart;
  logic     pace_tick;
  logic     addr_load;
  logic     addr_step;
  addr_t    src_ptr;
  addr_t    dst_ptr;
  logic     count_zero;

  // CPU side
  dma_regs regs_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .reg_addr   (reg_addr),
    .reg_rd     (reg_rd),
    .reg_wr     (reg_wr),
    .din        (din),
    .block_done (block_done),
    .cfg        (cfg),
    .dout       (dout),
    .oe_n       (oe_n)
  );

  dma_pace_timer timer_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .divisor      (cfg.divisor),
    .pace_restart (pace_restart),
    .pace_tick    (pace_tick)
  );

  dma_addr_gen addr_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .cfg        (cfg),
    .addr_load  (addr_load),
    .addr_step  (addr_step),
    .src_ptr    (src_ptr),
    .dst_ptr    (dst_ptr),
    .count_zero (count_zero)
  );

  // DMA bus side
  dma_seq_fsm seq_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg          (cfg),
    .pace_tick    (pace_tick),
    .src_ptr      (src_ptr),
    .dst_ptr      (dst_ptr),
    .count_zero   (count_zero),
    .busak_n      (busak_n),
    .dma_din      (dma_din),
    .busrq_n      (busrq_n),
    .bus          (bus),
    .pace_restart (pace_restart),
    .addr_load    (addr_load),
    .addr_step    (addr_step),
    .block_done   (block_done)
  );

endmodule

/* tb/zxdma_bus_model.sv */
module zxdma_bus_model import zxdma_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     busrq_n,
  input  dma_bus_t bus,
  output logic     busak_n,
  output byte_t    dma_din
);

  byte_t      mem [256];
  byte_t      io [256];
  integer     seed;
  logic [1:0] wait_cnt;
  logic [1:0] delay;
  logic       armed;

  // Fill depends on every address bit
  initial begin
    seed = 32'h39dbb677;
    for (int i = 0; i < 256; i++) begin
      mem[i] = byte_t'(i * 37 + 17);
      io[i]  = byte_t'(i * 91 + 200);
    end
  end

  //////////////////////////////////////////////////
  // Bus grant with a random delay
  //////////////////////////////////////////////////

  // Delay of 0 to 3 cycles from the first edge that sees the request
  always @(posedge clk) begin
    if (!rst_n) begin
      busak_n  <= 1'b1;
      armed    <= 1'b0;
      wait_cnt <= 2'd0;
    end else if (busrq_n) begin
      busak_n <= 1'b1;
      armed   <= 1'b0;
    end else if (busak_n) begin
      if (!armed) begin
        delay = 2'($random(seed));
        armed <= 1'b1;
        if (delay == 2'd0) begin
          busak_n <= 1'b0;
        end else begin
          wait_cnt <= delay - 2'd1;
        end
      end else if (wait_cnt == 2'd0) begin
        busak_n <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

  // Reads are combinational, writes land at the clock edge
  always_comb begin
    dma_din = 8'hFF;
    if (!bus.rd_n && !bus.mreq_n) begin
      dma_din = mem[bus.a[7:0]];
    end else if (!bus.rd_n && !bus.iorq_n) begin
      dma_din = io[bus.a[7:0]];
    end
  end

  always @(posedge clk) begin
    if (!bus.wr_n && !bus.mreq_n) begin
      mem[bus.a[7:0]] <= bus.dout;
    end
    if (!bus.wr_n && !bus.iorq_n) begin
      io[bus.a[7:0]] <= bus.dout;
    end
  end

endmodule

/* tb/tb_zxdma.sv */
module tb_zxdma import zxdma_pkg::*; ();

  // Per byte a pace period plus grant and cycle time, register traffic, 4x margin
  localparam int timeout_cycles = 4 * (18 * 10 + 4 * (10 + 9) + 6 * (5 + 9) + 6 * 80);

  logic     clk;
  logic     rst_n;
  byte_t    reg_addr;
  logic     reg_rd;
  logic     reg_wr;
  byte_t    din;
  byte_t    dout;
  logic     oe_n;
  logic     busrq_n;
  logic     busak_n;
  byte_t    dma_din;
  dma_bus_t bus;

  byte_t exp_mem [256];
  byte_t exp_io [256];
  byte_t exp_log [$];
  byte_t wr_log [$];
  int    cycle;
  int    errors;
  int    bus_errors;
  int    tests;
  int    failed_tests;
  int    err_at_start;
  int    io_wr_cnt;
  int    mem_wr_cnt;
  int    rq_falls;
  int    grant_wait;
  int    last_rise;
  int    min_gap;
  logic  busrq_q;
  logic  wr_n_q;

  zxdma_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .reg_addr (reg_addr),
    .reg_rd   (reg_rd),
    .reg_wr   (reg_wr),
    .din      (din),
    .dout     (dout),
    .oe_n     (oe_n),
    .busrq_n  (busrq_n),
    .busak_n  (busak_n),
    .dma_din  (dma_din),
    .bus      (bus)
  );

  zxdma_bus_model bus_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .busrq_n (busrq_n),
    .bus     (bus),
    .busak_n (busak_n),
    .dma_din (dma_din)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_cycles) begin
      $display("Timeout: a test stalled, run stopped after %0d cycles", cycle);
      $display("Checks failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Bus monitor, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin : monitor
    int adj;
    if (rst_n) begin
      if (busak_n && (!bus.mreq_n || !bus.iorq_n || !bus.rd_n || !bus.wr_n)) begin
        $display("Bus strobe active without a grant at cycle %0d", cycle);
        bus_errors++;
      end
      if (!bus.rd_n && !bus.wr_n) begin
        $display("rd_n and wr_n low together at cycle %0d", cycle);
        bus_errors++;
      end
      if (!bus.wr_n) begin
        wr_log.push_back(bus.dout);
        if (!bus.iorq_n) io_wr_cnt++;
        if (!bus.mreq_n) mem_wr_cnt++;
      end
      if (busrq_q && !busrq_n) begin
        rq_falls++;
        grant_wait = 0;
      end
      if (!busrq_n && busak_n) grant_wait++;
      // Grant latency taken out so the gap follows the pace timer
      if (!wr_n_q && bus.wr_n) begin
        adj = cycle - grant_wait;
        if (last_rise >= 0 && adj - last_rise < min_gap) min_gap = adj - last_rise;
        last_rise = adj;
      end
    end
    busrq_q = busrq_n;
    wr_n_q  = bus.wr_n;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic value_mismatch(input string name, input logic [15:0] got,
                                input logic [15:0] exp);
    $display("[FAIL] %s: got %h, expected %h", name, got, exp);
    errors++;
  endtask

  task automatic note_error(input string msg);
    $display("Error: %s", msg);
    errors++;
  endtask

  // Called on a falling edge; one idle cycle lets a wide byte shift in
  task automatic cpu_write(input byte_t addr, input byte_t data);
    reg_addr = addr;
    din      = data;
    reg_wr   = 1'b1;
    @(negedge clk);
    reg_wr = 1'b0;
    @(negedge clk);
  endtask

  task automatic write_word(input byte_t addr, input logic [15:0] value);
    cpu_write(addr, value[7:0]);
    cpu_write(addr, value[15:8]);
  endtask

  task automatic read_reg(input byte_t addr, output byte_t data, output logic oe);
    reg_addr = addr;
    reg_rd   = 1'b1;
    #5;
    data = dout;
    oe   = oe_n;
    @(negedge clk);
    reg_rd = 1'b0;
    @(negedge clk);
  endtask

  task automatic program_block(input dma_dir_t dir, input addr_t src, input addr_t dst,
                               input count_t div, input count_t len, input dma_mode_t mode);
    write_word(reg_src, src);
    write_word(reg_dst, dst);
    write_word(reg_div, div);
    write_word(reg_len, len);
    cpu_write(reg_ctrl, {4'b0000, dir, mode});
  endtask

  // Burst and timed clear the mode when the block ends
  task automatic wait_idle();
    byte_t v;
    logic  oe;
    read_reg(reg_ctrl, v, oe);
    while (v[1:0] != mode_off) begin
      read_reg(reg_ctrl, v, oe);
    end
  endtask

  task automatic take_snapshot();
    for (int i = 0; i < 256; i++) begin
      exp_mem[i] = bus_i.mem[i];
      exp_io[i]  = bus_i.io[i];
    end
  endtask

  task automatic compare_images();
    for (int i = 0; i < 256; i++) begin
      if (bus_i.mem[i] !== exp_mem[i]) begin
        value_mismatch($sformatf("mem[%02h]", i), bus_i.mem[i], exp_mem[i]);
      end
      if (bus_i.io[i] !== exp_io[i]) begin
        value_mismatch($sformatf("io[%02h]", i), bus_i.io[i], exp_io[i]);
      end
    end
  endtask

  // Memory side walks up, I/O side stays on its port
  function automatic void ref_copy(input dma_dir_t dir, input addr_t src, input addr_t dst,
                                   input count_t len);
    addr_t s;
    addr_t d;
    byte_t b;
    s = src;
    d = dst;
    for (int i = 0; i < int'(len); i++) begin
      b = dir[1] ? exp_io[s[7:0]] : exp_mem[s[7:0]];
      if (dir[0]) begin
        exp_io[d[7:0]] = b;
      end else begin
        exp_mem[d[7:0]] = b;
      end
      if (!dir[1]) s = s + 16'd1;
      if (!dir[0]) d = d + 16'd1;
    end
  endfunction

  task automatic begin_test();
    err_at_start = errors + bus_errors;
    io_wr_cnt    = 0;
    mem_wr_cnt   = 0;
    rq_falls     = 0;
    grant_wait   = 0;
    last_rise    = -1;
    min_gap      = 1000000;
    wr_log.delete();
    exp_log.delete();
  endtask

  task automatic end_test(input string name);
    int n;
    n = errors + bus_errors - err_at_start;
    tests++;
    if (n == 0) begin
      $display("Test %0d %s: ok", tests, name);
    end else begin
      failed_tests++;
      $display("Test %0d %s: %0d errors", tests, name, n);
    end
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    byte_t v;
    logic  oe;
    rst_n        = 1'b0;
    reg_addr     = 8'h00;
    reg_rd       = 1'b0;
    reg_wr       = 1'b0;
    din          = 8'h00;
    cycle        = 0;
    errors       = 0;
    bus_errors   = 0;
    tests        = 0;
    failed_tests = 0;
    busrq_q      = 1'b1;
    wr_n_q       = 1'b1;
    begin_test();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    begin_test();
    cpu_write(reg_ctrl, 8'h08);
    read_reg(reg_ctrl, v, oe);
    if (oe !== 1'b0) value_mismatch("oe_n", oe, 1'b0);
    if (v !== 8'h08) value_mismatch("dout", v, 8'h08);
    read_reg(reg_src, v, oe);
    if (oe !== 1'b1) value_mismatch("oe_n", oe, 1'b1);
    if (v !== 8'hFF) value_mismatch("dout", v, 8'hFF);
    read_reg(8'h3C, v, oe);
    if (oe !== 1'b1) value_mismatch("oe_n", oe, 1'b1);
    if (v !== 8'hFF) value_mismatch("dout", v, 8'hFF);
    end_test("register readback");

    begin_test();
    take_snapshot();
    ref_copy(2'b00, 16'h0010, 16'h0060, 16'd12);
    program_block(2'b00, 16'h0010, 16'h0060, 16'd0, 16'd12, mode_burst);
    wait_idle();
    compare_images();
    read_reg(reg_stat, v, oe);
    if (v !== 8'h80) value_mismatch("stat", v, 8'h80);
    read_reg(reg_stat, v, oe);
    if (v !== 8'h00) value_mismatch("stat", v, 8'h00);
    end_test("burst memory to memory");

    begin_test();
    take_snapshot();
    ref_copy(2'b01, 16'h0020, 16'h007F, 16'd6);
    program_block(2'b01, 16'h0020, 16'h007F, 16'd0, 16'd6, mode_burst);
    wait_idle();
    compare_images();
    if (io_wr_cnt != 6) value_mismatch("iorq_n writes", io_wr_cnt, 6);
    if (mem_wr_cnt != 0) value_mismatch("mreq_n writes", mem_wr_cnt, 0);
    if (bus_i.io[8'h7F] !== exp_mem[8'h25]) begin
      value_mismatch("io[7f]", bus_i.io[8'h7F], exp_mem[8'h25]);
    end
    end_test("burst memory to I/O");

    begin_test();
    take_snapshot();
    ref_copy(2'b00, 16'h0030, 16'h00A0, 16'd4);
    program_block(2'b00, 16'h0030, 16'h00A0, 16'd9, 16'd4, mode_timed);
    wait_idle();
    compare_images();
    if (rq_falls != 4) value_mismatch("busrq_n falls", rq_falls, 4);
    if (min_gap < 10) note_error($sformatf("wr_n rises paced only %0d cycles apart", min_gap));
    end_test("timed transfer");

    // Restart block sent twice, then stopped
    begin_test();
    take_snapshot();
    for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < 3; i++) begin
        exp_log.push_back(exp_mem[8'h40 + i]);
      end
      ref_copy(2'b00, 16'h0040, 16'h00C0, 16'd3);
    end
    program_block(2'b00, 16'h0040, 16'h00C0, 16'd4, 16'd3, mode_restart);
    while (wr_log.size() < 6) @(negedge clk);
    cpu_write(reg_ctrl, 8'h00);
    repeat (40) @(negedge clk);
    if (wr_log.size() != 6) begin
      note_error($sformatf("%0d bytes written with restart, 6 expected", wr_log.size()));
    end else begin
      for (int i = 0; i < 6; i++) begin
        if (wr_log[i] !== exp_log[i]) begin
          value_mismatch($sformatf("write %0d", i), wr_log[i], exp_log[i]);
        end
      end
    end
    compare_images();
    read_reg(reg_ctrl, v, oe);
    if (v[1:0] !== mode_off) value_mismatch("ctrl mode", v[1:0], mode_off);
    end_test("timed with restart");

    $display("Tests: %0d, failed: %0d, errors: %0d", tests, failed_tests, errors + bus_errors);
    if (errors + bus_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* zxdma.f */
design/zxdma_pkg.sv
design/dma_regs.sv
design/dma_pace_timer.sv
design/dma_addr_gen.sv
design/dma_seq_fsm.sv
design/zxdma_top.sv
tb/zxdma_bus_model.sv
tb/tb_zxdma.sv

/* Makefile */
TOP = tb_zxdma

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f zxdma.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
